// ==== Bender.yml ====
package:
  name: msx_opm_cartridge

sources:
  - src/opm_cart_pkg.sv
  - src/opm_bus_decoder.sv
  - src/opm_register_file.sv
  - src/opm_timer.sv
  - src/opm_tone_generator.sv
  - src/opm_stereo_mixer.sv
  - src/msx_opm_cartridge.sv
  - target: simulation
    files:
      - verification/tb_msx_opm_cartridge.sv

// ==== msx_opm_cartridge.f ====
src/opm_cart_pkg.sv
src/opm_bus_decoder.sv
src/opm_register_file.sv
src/opm_timer.sv
src/opm_tone_generator.sv
src/opm_stereo_mixer.sv
src/msx_opm_cartridge.sv
verification/tb_msx_opm_cartridge.sv

// ==== src/msx_opm_cartridge.sv ====
// FM sound cartridge top level
// Slot bus decoder in front of the register file, timer, tone
// generator and stereo mixer
`timescale 1ns/10ps

module msx_opm_cartridge (
	input  logic        clk,
	input  logic        n_reset,
	input  logic        i_n_memreq,
	input  logic        i_n_sltsl,
	input  logic        i_n_wr,
	input  logic        i_n_rd,
	input  logic [15:0] i_address,
	input  logic [7:0]  i_wdata,
	input  logic        i_mclk_pcen_n,
	output logic [7:0]  o_rdata,
	output logic        o_rdata_en,
	output logic signed [opm_cart_pkg::OUT_BITS-1:0] o_sound_out,
	output logic        o_opm_int_n
);
	logic        w_addr_wr;
	logic        w_data_wr;
	logic [7:0]  w_status;
	logic [opm_cart_pkg::TIMER_BITS-1:0] w_timer_load;
	logic        w_timer_run;
	logic        w_timer_irq_en;
	logic        w_timer_clear;
	logic        w_timer_flag;
	logic [opm_cart_pkg::NUM_CHANNELS-1:0] w_key_on;
	logic [opm_cart_pkg::NUM_CHANNELS*opm_cart_pkg::FREQ_BITS-1:0] w_freq;
	logic [opm_cart_pkg::NUM_CHANNELS*opm_cart_pkg::VOL_BITS-1:0] w_vol;
	logic [opm_cart_pkg::NUM_CHANNELS*2-1:0] w_pan;
	logic        w_slot_valid;
	logic        w_slot_last;
	logic signed [opm_cart_pkg::SAMPLE_BITS-1:0] w_sample;
	logic        w_to_left;
	logic        w_to_right;

	opm_bus_decoder u_bus_decoder (
		.clk(clk), .n_reset(n_reset),
		.i_n_memreq(i_n_memreq), .i_n_sltsl(i_n_sltsl), .i_n_wr(i_n_wr), .i_n_rd(i_n_rd),
		.i_address(i_address), .i_status(w_status),
		.o_addr_wr(w_addr_wr), .o_data_wr(w_data_wr),
		.o_rdata(o_rdata), .o_rdata_en(o_rdata_en)
	);

	opm_register_file u_register_file (
		.clk(clk), .n_reset(n_reset),
		.i_addr_wr(w_addr_wr), .i_data_wr(w_data_wr), .i_wdata(i_wdata),
		.i_timer_flag(w_timer_flag), .o_status(w_status),
		.o_timer_load(w_timer_load), .o_timer_run(w_timer_run),
		.o_timer_irq_en(w_timer_irq_en), .o_timer_clear(w_timer_clear),
		.o_key_on(w_key_on), .o_freq(w_freq), .o_vol(w_vol), .o_pan(w_pan)
	);

	opm_timer u_timer (
		.clk(clk), .n_reset(n_reset), .i_mclk_pcen_n(i_mclk_pcen_n),
		.i_load(w_timer_load), .i_run(w_timer_run), .i_irq_en(w_timer_irq_en),
		.i_clear(w_timer_clear), .o_flag(w_timer_flag), .o_opm_int_n(o_opm_int_n)
	);

	opm_tone_generator u_tone_generator (
		.clk(clk), .n_reset(n_reset), .i_mclk_pcen_n(i_mclk_pcen_n),
		.i_key_on(w_key_on), .i_freq(w_freq), .i_vol(w_vol), .i_pan(w_pan),
		.o_slot_valid(w_slot_valid), .o_slot_last(w_slot_last), .o_sample(w_sample),
		.o_to_left(w_to_left), .o_to_right(w_to_right)
	);

	opm_stereo_mixer u_stereo_mixer (
		.clk(clk), .n_reset(n_reset),
		.i_slot_valid(w_slot_valid), .i_slot_last(w_slot_last), .i_sample(w_sample),
		.i_to_left(w_to_left), .i_to_right(w_to_right), .o_sound_out(o_sound_out)
	);

endmodule

// ==== src/opm_bus_decoder.sv ====
// FM cartridge slot bus decoder
// Chip select and write pulses for the OPM ports, signature ROM reads
// and the read data mux with its registered enable
`timescale 1ns/10ps

module opm_bus_decoder (
	input  logic        clk,
	input  logic        n_reset,
	input  logic        i_n_memreq,
	input  logic        i_n_sltsl,
	input  logic        i_n_wr,
	input  logic        i_n_rd,
	input  logic [15:0] i_address,
	input  logic [7:0]  i_status,
	output logic        o_addr_wr,
	output logic        o_data_wr,
	output logic [7:0]  o_rdata,
	output logic        o_rdata_en
);
	logic       w_cs;		// Chip window selected
	logic       w_sig_win;		// Address inside signature window
	logic       w_chip_rd;
	logic       w_rom_rd;
	logic       w_wr_now;
	logic       w_wr_pulse;
	logic       ff_wr_d;		// Write seen on previous clock
	logic       ff_rom_sel;
	logic       ff_rdata_en;
	logic [7:0] ff_rom_rdata;

	// ------------------------------------------------------------
	// Address decode
	// ------------------------------------------------------------
	assign w_cs = ({i_address[15], 1'b0, i_address[13:1], 1'b0} == opm_cart_pkg::CHIP_IO_ADDR)
			& ~i_n_sltsl & ~i_n_memreq;
	assign w_sig_win = ({i_address[15:4], 4'h0} == opm_cart_pkg::SIGNATURE_BASE);

	// Writes: one pulse per bus cycle, port chosen by A0
	assign w_wr_now   = w_cs & ~i_n_wr;
	assign w_wr_pulse = w_wr_now & ~ff_wr_d;	// Leading edge only
	assign o_addr_wr  = w_wr_pulse & ~i_address[0];
	assign o_data_wr  = w_wr_pulse & i_address[0];

	// Reads
	assign w_chip_rd = w_cs & ~i_n_rd;	// Any mirror of the chip window
	assign w_rom_rd  = ~i_n_sltsl & ~i_n_rd & (i_address[15:14] == 2'd0) & w_sig_win;

	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_wr_d     <= 1'b0;
			ff_rom_sel  <= 1'b0;
			ff_rdata_en <= 1'b0;
		end else begin
			ff_wr_d     <= w_wr_now;
			ff_rom_sel  <= w_rom_rd;
			ff_rdata_en <= w_rom_rd | w_chip_rd;
		end
	end

	// ------------------------------------------------------------
	// Signature ROM
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (w_sig_win && (i_address[3:0] < opm_cart_pkg::SIGNATURE_LEN)) begin
			ff_rom_rdata <= opm_cart_pkg::SIGNATURE_ROM[i_address[3:0]];
		end else begin
			ff_rom_rdata <= opm_cart_pkg::ROM_FILL_BYTE;	// Rest of window
		end
	end

	assign o_rdata    = ff_rom_sel ? ff_rom_rdata : i_status;	// ROM wins over status
	assign o_rdata_en = ff_rdata_en;

endmodule

// ==== src/opm_cart_pkg.sv ====
// FM sound cartridge shared definitions
// Bus map, register map, timing constants and datapath widths
package opm_cart_pkg;

	// ------------------------------------------------------------
	// Slot bus map
	// ------------------------------------------------------------
	localparam logic [15:0] CHIP_IO_ADDR   = 16'h3FF0;	// Bits 14 and 0 masked
	localparam logic [15:0] SIGNATURE_BASE = 16'h0080;	// 16-byte signature window
	localparam int          SIGNATURE_LEN  = 9;
	localparam logic [7:0]  SIGNATURE_ROM [0:SIGNATURE_LEN-1] = '{
		8'h4D,	// 'M'
		8'h43,	// 'C'
		8'h48,	// 'H'
		8'h46,	// 'F'
		8'h4D,	// 'M'
		8'h30,	// '0'
		8'h08,	// ROM serial
		8'h00,	// Sound chip type
		8'h00	// Software version
	};
	localparam logic [7:0]  ROM_FILL_BYTE  = 8'hC9;	// RET opcode

	// ------------------------------------------------------------
	// Register map
	// ------------------------------------------------------------
	localparam int          NUM_CHANNELS   = 8;
	localparam int          CH_BITS        = 3;
	localparam logic [7:0]  REG_KEY_ON     = 8'h08;	// [3] key, [2:0] channel
	localparam logic [7:0]  REG_TIMER_A_HI = 8'h10;
	localparam logic [7:0]  REG_TIMER_A_LO = 8'h11;
	localparam logic [7:0]  REG_TIMER_CTRL = 8'h14;	// [0] run, [2] irq en, [4] clear
	localparam logic [7:0]  REG_PAN_BASE   = 8'h20;	// [7] right, [6] left
	localparam logic [7:0]  REG_FREQ_BASE  = 8'h28;
	localparam logic [7:0]  REG_VOL_BASE   = 8'h60;

	// ------------------------------------------------------------
	// Timing and widths
	// ------------------------------------------------------------
	localparam int          BUSY_CYCLES    = 32;	// Clocks of busy after a data write
	localparam int          TIMER_PRESCALE = 64;	// Enables per timer tick
	localparam int          TIMER_BITS     = 10;
	localparam int          FREQ_BITS      = 8;	// Phase increment per channel
	localparam int          VOL_BITS       = 7;
	localparam int          PHASE_BITS     = 16;
	localparam int          SAMPLE_BITS    = 16;
	localparam int          AMP_SHIFT      = 5;	// Peak slot amplitude 127 << 5
	localparam int          OUT_BITS       = 17;

endpackage

// ==== src/opm_register_file.sv ====
// OPM register file
// Address latch, channel and timer registers, key-on bits, busy flag
// and the status byte returned on chip reads
`timescale 1ns/10ps

module opm_register_file (
	input  logic        clk,
	input  logic        n_reset,
	input  logic        i_addr_wr,
	input  logic        i_data_wr,
	input  logic [7:0]  i_wdata,
	input  logic        i_timer_flag,
	output logic [7:0]  o_status,
	output logic [opm_cart_pkg::TIMER_BITS-1:0] o_timer_load,
	output logic        o_timer_run,
	output logic        o_timer_irq_en,
	output logic        o_timer_clear,
	output logic [opm_cart_pkg::NUM_CHANNELS-1:0] o_key_on,
	output logic [opm_cart_pkg::NUM_CHANNELS*opm_cart_pkg::FREQ_BITS-1:0] o_freq,
	output logic [opm_cart_pkg::NUM_CHANNELS*opm_cart_pkg::VOL_BITS-1:0] o_vol,
	output logic [opm_cart_pkg::NUM_CHANNELS*2-1:0] o_pan
);
	localparam int BUSY_W = $clog2(opm_cart_pkg::BUSY_CYCLES + 1);
	localparam int CH_B   = opm_cart_pkg::CH_BITS;
	localparam int FREQ_B = opm_cart_pkg::FREQ_BITS;
	localparam int VOL_B  = opm_cart_pkg::VOL_BITS;

	logic [7:0]        ff_addr;		// Selected register
	logic [7:0]        ff_timer_hi;
	logic [opm_cart_pkg::TIMER_BITS-9:0] ff_timer_lo;
	logic              ff_run;
	logic              ff_irq_en;
	logic              ff_clear;
	logic [BUSY_W-1:0] ff_busy_cnt;
	logic [7:0]        w_reg_base;		// Register group base
	logic [CH_B-1:0]   w_ch;		// Channel within group

	assign w_ch       = ff_addr[CH_B-1:0];
	assign w_reg_base = {ff_addr[7:CH_B], {CH_B{1'b0}}};

	// ------------------------------------------------------------
	// Register writes
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_addr     <= '0;
			ff_timer_hi <= '0;
			ff_timer_lo <= '0;
			ff_run      <= 1'b0;
			ff_irq_en   <= 1'b0;
			ff_clear    <= 1'b0;
			o_key_on    <= '0;
			o_freq      <= '0;
			o_vol       <= '0;
			o_pan       <= '0;
		end else begin
			ff_clear <= 1'b0;		// Single clock pulse
			if (i_addr_wr) begin
				ff_addr <= i_wdata;
			end
			if (i_data_wr) begin
				case (ff_addr)
					opm_cart_pkg::REG_KEY_ON:     o_key_on[i_wdata[CH_B-1:0]] <= i_wdata[3];
					opm_cart_pkg::REG_TIMER_A_HI: ff_timer_hi <= i_wdata;
					opm_cart_pkg::REG_TIMER_A_LO: ff_timer_lo <= i_wdata[1:0];
					opm_cart_pkg::REG_TIMER_CTRL: begin
						ff_run    <= i_wdata[0];
						ff_irq_en <= i_wdata[2];
						ff_clear  <= i_wdata[4];
					end
					default: ;
				endcase
				if (w_reg_base == opm_cart_pkg::REG_PAN_BASE) begin
					o_pan[w_ch*2 +: 2] <= i_wdata[7:6];	// {right, left}
				end
				if (w_reg_base == opm_cart_pkg::REG_FREQ_BASE) begin
					o_freq[w_ch*FREQ_B +: FREQ_B] <= i_wdata;
				end
				if (w_reg_base == opm_cart_pkg::REG_VOL_BASE) begin
					o_vol[w_ch*VOL_B +: VOL_B] <= i_wdata[VOL_B-1:0];
				end
			end
		end
	end

	// Busy window after each data write
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_busy_cnt <= '0;
		end else if (i_data_wr) begin
			ff_busy_cnt <= BUSY_W'(opm_cart_pkg::BUSY_CYCLES);
		end else if (ff_busy_cnt != '0) begin
			ff_busy_cnt <= ff_busy_cnt - 1'b1;
		end
	end

	assign o_status       = {(ff_busy_cnt != '0), 6'b0, i_timer_flag};
	assign o_timer_load   = {ff_timer_hi, ff_timer_lo};
	assign o_timer_run    = ff_run;
	assign o_timer_irq_en = ff_irq_en;
	assign o_timer_clear  = ff_clear;

endmodule

// ==== src/opm_stereo_mixer.sv ====
// Stereo frame mixer
// Sums routed slot samples per frame and outputs left plus right
`timescale 1ns/10ps

module opm_stereo_mixer (
	input  logic        clk,
	input  logic        n_reset,
	input  logic        i_slot_valid,
	input  logic        i_slot_last,
	input  logic signed [opm_cart_pkg::SAMPLE_BITS-1:0] i_sample,
	input  logic        i_to_left,
	input  logic        i_to_right,
	output logic signed [opm_cart_pkg::OUT_BITS-1:0] o_sound_out
);
	localparam int SMP_B = opm_cart_pkg::SAMPLE_BITS;

	// Eight full-scale slots stay inside 16 bits per side
	logic signed [SMP_B-1:0] ff_sum_l;
	logic signed [SMP_B-1:0] ff_sum_r;
	logic signed [SMP_B-1:0] w_next_l;
	logic signed [SMP_B-1:0] w_next_r;

	assign w_next_l = ff_sum_l + (i_to_left ? i_sample : SMP_B'(0));
	assign w_next_r = ff_sum_r + (i_to_right ? i_sample : SMP_B'(0));

	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_sum_l    <= '0;
			ff_sum_r    <= '0;
			o_sound_out <= '0;
		end else if (i_slot_valid) begin
			if (i_slot_last) begin
				// Frame done, sign extend and combine both sides
				o_sound_out <= {w_next_l[SMP_B-1], w_next_l} + {w_next_r[SMP_B-1], w_next_r};
				ff_sum_l    <= '0;
				ff_sum_r    <= '0;
			end else begin
				ff_sum_l <= w_next_l;
				ff_sum_r <= w_next_r;
			end
		end
	end

endmodule

// ==== src/opm_timer.sv ====
// OPM timer A
// Prescaled 10-bit up counter with reload, sticky overflow flag
// and an active-low interrupt output
`timescale 1ns/10ps

module opm_timer (
	input  logic        clk,
	input  logic        n_reset,
	input  logic        i_mclk_pcen_n,
	input  logic [opm_cart_pkg::TIMER_BITS-1:0] i_load,
	input  logic        i_run,
	input  logic        i_irq_en,
	input  logic        i_clear,
	output logic        o_flag,
	output logic        o_opm_int_n
);
	localparam int PRE_W = $clog2(opm_cart_pkg::TIMER_PRESCALE);

	logic [PRE_W-1:0]                   ff_prescale;
	logic [opm_cart_pkg::TIMER_BITS-1:0] ff_count;
	logic                               w_ce;
	logic                               w_tick;
	logic                               w_overflow;

	assign w_ce       = ~i_mclk_pcen_n;
	assign w_tick     = i_run & w_ce & (ff_prescale == PRE_W'(opm_cart_pkg::TIMER_PRESCALE - 1));
	assign w_overflow = w_tick & (&ff_count);	// Tick on all ones

	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_prescale <= '0;
			ff_count    <= '0;
		end else if (!i_run) begin
			ff_prescale <= '0;
			ff_count    <= i_load;	// Preload while stopped
		end else begin
			if (w_tick) begin
				ff_prescale <= '0;
				ff_count    <= w_overflow ? i_load : ff_count + 1'b1;
			end else if (w_ce) begin
				ff_prescale <= ff_prescale + 1'b1;
			end
		end
	end

	// Flag is sticky, clear has priority
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			o_flag      <= 1'b0;
			o_opm_int_n <= 1'b1;
		end else begin
			if (i_clear) begin
				o_flag <= 1'b0;
			end else if (w_overflow) begin
				o_flag <= 1'b1;
			end
			o_opm_int_n <= ~(o_flag & i_irq_en);
		end
	end

endmodule

// ==== src/opm_tone_generator.sv ====
// Eight-channel square-wave tone generator
// One channel slot per clock enable, each with its own phase accumulator,
// volume and left/right routing
`timescale 1ns/10ps

module opm_tone_generator (
	input  logic        clk,
	input  logic        n_reset,
	input  logic        i_mclk_pcen_n,
	input  logic [opm_cart_pkg::NUM_CHANNELS-1:0] i_key_on,
	input  logic [opm_cart_pkg::NUM_CHANNELS*opm_cart_pkg::FREQ_BITS-1:0] i_freq,
	input  logic [opm_cart_pkg::NUM_CHANNELS*opm_cart_pkg::VOL_BITS-1:0] i_vol,
	input  logic [opm_cart_pkg::NUM_CHANNELS*2-1:0] i_pan,
	output logic        o_slot_valid,
	output logic        o_slot_last,
	output logic signed [opm_cart_pkg::SAMPLE_BITS-1:0] o_sample,
	output logic        o_to_left,
	output logic        o_to_right
);
	localparam int CH_B   = opm_cart_pkg::CH_BITS;
	localparam int PH_B   = opm_cart_pkg::PHASE_BITS;
	localparam int SMP_B  = opm_cart_pkg::SAMPLE_BITS;
	localparam int FREQ_B = opm_cart_pkg::FREQ_BITS;
	localparam int VOL_B  = opm_cart_pkg::VOL_BITS;
	localparam int SHIFT  = opm_cart_pkg::AMP_SHIFT;

	logic [CH_B-1:0]         ff_slot;	// Current channel slot
	logic [PH_B-1:0]         ff_phase [opm_cart_pkg::NUM_CHANNELS];
	logic                    w_ce;
	logic                    w_key;
	logic [FREQ_B-1:0]       w_freq;
	logic [VOL_B-1:0]        w_vol;
	logic signed [SMP_B-1:0] w_amp;

	assign w_ce   = ~i_mclk_pcen_n;
	assign w_key  = i_key_on[ff_slot];
	assign w_freq = i_freq[ff_slot*FREQ_B +: FREQ_B];
	assign w_vol  = i_vol[ff_slot*VOL_B +: VOL_B];
	assign w_amp  = {{(SMP_B-VOL_B-SHIFT){1'b0}}, w_vol, {SHIFT{1'b0}}};	// vol << 5

	// ------------------------------------------------------------
	// Slot counter and phase accumulators
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_slot <= '0;
			for (int i = 0; i < opm_cart_pkg::NUM_CHANNELS; i++) begin
				ff_phase[i] <= '0;
			end
		end else if (w_ce) begin
			ff_slot <= ff_slot + 1'b1;	// Wraps after slot 7
			if (w_key) begin
				ff_phase[ff_slot] <= ff_phase[ff_slot] + PH_B'(w_freq);
			end else begin
				ff_phase[ff_slot] <= '0;	// Restart tone on next key-on
			end
		end
	end

	// ------------------------------------------------------------
	// Registered slot output
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			o_slot_valid <= 1'b0;
			o_slot_last  <= 1'b0;
			o_sample     <= '0;
			o_to_left    <= 1'b0;
			o_to_right   <= 1'b0;
		end else begin
			o_slot_valid <= w_ce;
			o_slot_last  <= w_ce & (ff_slot == CH_B'(opm_cart_pkg::NUM_CHANNELS - 1));
			if (w_ce) begin
				if (!w_key) begin
					o_sample <= '0;
				end else begin
					o_sample <= ff_phase[ff_slot][PH_B-1] ? -w_amp : w_amp;	// Square by MSB
				end
				o_to_left  <= i_pan[ff_slot*2];
				o_to_right <= i_pan[ff_slot*2+1];
			end
		end
	end

endmodule

// ==== verification/tb_msx_opm_cartridge.sv ====
// Testbench for the FM sound cartridge
// Runs MSX slot bus cycles and checks signature reads, busy flag,
// chip window mirrors, tone output levels and the timer A interrupt
`timescale 1ns/10ps

module tb_msx_opm_cartridge;
	logic        clk;
	logic        n_reset;
	logic        i_n_memreq;
	logic        i_n_sltsl;
	logic        i_n_wr;
	logic        i_n_rd;
	logic [15:0] i_address;
	logic [7:0]  i_wdata;
	logic        i_mclk_pcen_n;
	logic [7:0]  o_rdata;
	logic        o_rdata_en;
	logic signed [16:0] o_sound_out;
	logic        o_opm_int_n;

	int          errors;
	int          seed;
	logic [1:0]  ce_phase;
	logic        use_mirror;	// Alternates 0x3FFx and 0x7FFx
	logic [7:0]  sig_bytes [9] = '{8'h4D, 8'h43, 8'h48, 8'h46, 8'h4D, 8'h30, 8'h08, 8'h00, 8'h00};

	msx_opm_cartridge UUT (
		.clk(clk), .n_reset(n_reset),
		.i_n_memreq(i_n_memreq), .i_n_sltsl(i_n_sltsl), .i_n_wr(i_n_wr), .i_n_rd(i_n_rd),
		.i_address(i_address), .i_wdata(i_wdata), .i_mclk_pcen_n(i_mclk_pcen_n),
		.o_rdata(o_rdata), .o_rdata_en(o_rdata_en),
		.o_sound_out(o_sound_out), .o_opm_int_n(o_opm_int_n)
	);

	always #4 clk = ~clk;	// 8 ns period

	// Core clock enable, one cycle in four
	always @(posedge clk) begin
		#1;
		ce_phase = ce_phase + 1'b1;
		i_mclk_pcen_n = (ce_phase != 2'd0);
	end

	// ------------------------------------------------------------
	// Bus tasks
	// ------------------------------------------------------------
	task automatic write_mem(input logic [15:0] addr, input logic [7:0] data);
		@(posedge clk);
		#1;
		i_address = addr;
		i_wdata = data;
		i_n_sltsl = 1'b0;
		i_n_memreq = 1'b0;
		i_n_wr = 1'b0;
		repeat (2) @(posedge clk);	// Strobe held two clocks
		#1;
		i_n_wr = 1'b1;
		i_n_sltsl = 1'b1;
		i_n_memreq = 1'b1;
	endtask

	task automatic read_mem(input logic [15:0] addr, output logic [7:0] data, output logic en);
		@(posedge clk);
		#1;
		i_address = addr;
		i_n_sltsl = 1'b0;
		i_n_memreq = 1'b0;
		i_n_rd = 1'b0;
		@(posedge clk);
		#1;
		data = o_rdata;	// Enable registered, valid one clock later
		en = o_rdata_en;
		i_n_rd = 1'b1;
		i_n_sltsl = 1'b1;
		i_n_memreq = 1'b1;
	endtask

	task automatic check_eq(input string name, input int expected, input int actual);
		assert (expected == actual) else begin
			errors++;
			$display("Fail %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	task automatic wait_ready();
		logic [7:0] d;
		logic       en;
		int         n;
		d = 8'h80;
		n = 0;
		while (d[7] && n < 50) begin
			read_mem(16'h3FF0, d, en);
			n++;
		end
		assert (!d[7]) else begin
			errors++;
			$display("Timeout: busy flag still set after %0d status polls", n);
		end
	endtask

	task automatic write_reg(input logic [7:0] reg_addr, input logic [7:0] val);
		logic [15:0] base;
		wait_ready();
		base = use_mirror ? 16'h7FF0 : 16'h3FF0;
		use_mirror = ~use_mirror;
		write_mem(base, reg_addr);	// Address port
		write_mem(base | 16'h1, val);	// Data port
	endtask

	// Every frame total must be a sum or difference of the channel levels
	task automatic sample_sound(input string name, input int cycles, input int amp_a,
			input int amp_b, output int n_pos, output int n_neg);
		int   s;
		int   mag;
		logic ok;
		n_pos = 0;
		n_neg = 0;
		for (int i = 0; i < cycles; i++) begin
			@(posedge clk);
			#1;
			s = o_sound_out;
			mag = (s < 0) ? -s : s;
			ok = (mag == 0) || (mag == amp_a) || (mag == amp_b) || (mag == amp_a + amp_b)
				|| (mag == amp_a - amp_b) || (mag == amp_b - amp_a);
			assert (ok) else begin
				errors++;
				$display("Fail %s: expected magnitude 0, %0d, %0d or their sum/difference, actual %0d",
					name, amp_a, amp_b, s);
			end
			if (s > 0) n_pos++;
			if (s < 0) n_neg++;
		end
	endtask

	task automatic wait_silence(input string name);
		int n;
		n = 0;
		while (o_sound_out != 0 && n < 300) begin
			@(posedge clk);
			#1;
			n++;
		end
		assert (o_sound_out == 0) else begin
			errors++;
			$display("Timeout in %s: sound output did not settle to zero", name);
		end
	endtask

	// ------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------
	initial begin
		logic [7:0]  d;
		logic        en;
		logic [15:0] addr;
		logic [2:0]  ch;
		int          v1;
		int          v2;
		int          n_pos;
		int          n_neg;
		int          cnt;
		clk = 1'b0;
		n_reset = 1'b0;
		i_n_memreq = 1'b1;
		i_n_sltsl = 1'b1;
		i_n_wr = 1'b1;
		i_n_rd = 1'b1;
		i_address = 16'h0000;
		i_wdata = 8'h00;
		i_mclk_pcen_n = 1'b1;
		ce_phase = 2'd0;
		use_mirror = 1'b0;
		errors = 0;
		seed = 32'h982d_cc13;
		repeat (3) @(posedge clk);
		#1;
		n_reset = 1'b1;
		@(posedge clk);
		#1;
		check_eq("reset_rdata_en", 0, o_rdata_en);
		check_eq("reset_int_n", 1, o_opm_int_n);
		check_eq("reset_sound", 0, o_sound_out);

		// Signature area and upper 48 KB
		for (int i = 0; i < 9; i++) begin
			read_mem(16'h0080 + i, d, en);
			check_eq("signature_en", 1, en);
			check_eq("signature_byte", sig_bytes[i], d);
		end
		read_mem(16'h0089, d, en);
		check_eq("signature_fill_en", 1, en);
		check_eq("signature_fill", 8'hC9, d);
		for (int i = 0; i < 6; i++) begin
			addr = $random(seed);
			if (addr[15:14] == 2'd0) addr[15] = 1'b1;
			addr[4] = 1'b0;	// Keeps clear of the chip window mirror
			read_mem(addr, d, en);
			check_eq("upper_read_en", 0, en);
		end

		// Busy flag after a data write through the upper mirror
		wait_ready();
		write_mem(16'h7FF0, opm_cart_pkg::REG_FREQ_BASE + 8'd7);
		write_mem(16'h7FF1, 8'h10);
		read_mem(16'h3FF1, d, en);
		check_eq("busy_set", 1, d[7]);
		wait_ready();

		// Chip window mirrors and writes outside the window
		addr = 16'h3FF0;
		for (int i = 0; i < 4; i++) begin
			read_mem(addr | i[0] | (i[1] << 14), d, en);
			check_eq("mirror_read_en", 1, en);
			check_eq("mirror_status", 8'h00, d);
		end
		write_reg(opm_cart_pkg::REG_VOL_BASE, 8'h00);
		write_reg(opm_cart_pkg::REG_PAN_BASE, 8'hC0);
		write_reg(opm_cart_pkg::REG_FREQ_BASE, 8'hFF);
		write_mem(16'h3FF0, opm_cart_pkg::REG_VOL_BASE);
		write_mem(16'hBFF1, 8'h7F);	// Bit 15 set, not the chip
		write_mem(16'h3FE1, 8'h7F);
		write_reg(opm_cart_pkg::REG_KEY_ON, 8'h08);
		sample_sound("outside_write", 800, 0, 0, n_pos, n_neg);
		write_reg(opm_cart_pkg::REG_KEY_ON, 8'h00);

		// One channel, both pans, then left only
		ch = $random(seed);
		v1 = 1 + ({$random(seed)} % 127);
		write_reg(opm_cart_pkg::REG_VOL_BASE + ch, v1);
		write_reg(opm_cart_pkg::REG_FREQ_BASE + ch, 8'hFF);
		write_reg(opm_cart_pkg::REG_PAN_BASE + ch, 8'hC0);
		write_reg(opm_cart_pkg::REG_KEY_ON, 8'h08 | ch);
		sample_sound("both_pans", 10000, 2 * (v1 << 5), 0, n_pos, n_neg);
		assert (n_pos > 0 && n_neg > 0) else begin
			errors++;
			$display("Square wave with both pans did not show both signs");
		end
		write_reg(opm_cart_pkg::REG_PAN_BASE + ch, 8'h40);
		repeat (100) @(posedge clk);	// Let the old frame drain
		sample_sound("left_pan", 10000, v1 << 5, 0, n_pos, n_neg);
		assert (n_pos > 0 && n_neg > 0) else begin
			errors++;
			$display("Square wave with left pan did not show both signs");
		end
		write_reg(opm_cart_pkg::REG_KEY_ON, {5'b0, ch});
		wait_silence("key_off");

		// Two channels at once
		v1 = 1 + ({$random(seed)} % 127);
		v2 = 1 + ({$random(seed)} % 127);
		write_reg(opm_cart_pkg::REG_VOL_BASE + 8'd1, v1);
		write_reg(opm_cart_pkg::REG_FREQ_BASE + 8'd1, 8'hFF);
		write_reg(opm_cart_pkg::REG_PAN_BASE + 8'd1, 8'hC0);
		write_reg(opm_cart_pkg::REG_VOL_BASE + 8'd6, v2);
		write_reg(opm_cart_pkg::REG_FREQ_BASE + 8'd6, 8'hB0);
		write_reg(opm_cart_pkg::REG_PAN_BASE + 8'd6, 8'h80);	// Right only
		write_reg(opm_cart_pkg::REG_KEY_ON, 8'h09);
		write_reg(opm_cart_pkg::REG_KEY_ON, 8'h0E);
		sample_sound("two_channels", 12000, 2 * (v1 << 5), v2 << 5, n_pos, n_neg);
		write_reg(opm_cart_pkg::REG_KEY_ON, 8'h01);
		write_reg(opm_cart_pkg::REG_KEY_ON, 8'h06);
		wait_silence("two_key_off");

		// Timer A, load 0x3FE overflows after two ticks
		write_reg(opm_cart_pkg::REG_TIMER_A_HI, 8'hFF);
		write_reg(opm_cart_pkg::REG_TIMER_A_LO, 8'h02);
		write_reg(opm_cart_pkg::REG_TIMER_CTRL, 8'h05);
		cnt = 0;
		while (o_opm_int_n && cnt < 3000) begin
			@(posedge clk);
			#1;
			cnt++;
		end
		assert (!o_opm_int_n) else begin
			errors++;
			$display("Timeout: timer A interrupt never asserted");
		end
		read_mem(16'h3FF0, d, en);
		check_eq("timer_flag_set", 1, d[0]);
		write_reg(opm_cart_pkg::REG_TIMER_CTRL, 8'h15);
		cnt = 0;
		while (!o_opm_int_n && cnt < 20) begin
			@(posedge clk);
			#1;
			cnt++;
		end
		assert (o_opm_int_n) else begin
			errors++;
			$display("Timeout: interrupt stayed low after flag clear");
		end
		read_mem(16'h3FF0, d, en);
		check_eq("timer_flag_cleared", 0, d[0]);
		write_reg(opm_cart_pkg::REG_TIMER_CTRL, 8'h11);	// Run, irq off
		cnt = 0;
		d = 8'h00;
		while (!d[0] && cnt < 1000) begin
			read_mem(16'h3FF0, d, en);
			assert (o_opm_int_n) else begin
				errors++;
				$display("Interrupt asserted while interrupt enable was off");
			end
			cnt++;
		end
		assert (d[0]) else begin
			errors++;
			$display("Timeout: timer flag never set with interrupt enable off");
		end
		repeat (4) @(posedge clk);
		#1;
		check_eq("int_masked", 1, o_opm_int_n);
		write_reg(opm_cart_pkg::REG_TIMER_CTRL, 8'h10);

		$display("Errors: %0d", errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule
